//--- all.f
source/portalPkg.sv
source/portalBeatIf.sv
source/syncFifo.sv
source/burstSplitter.sv
source/portalRead.sv
source/portalWrite.sv
source/messageAssembler.sv
source/indicationBuffer.sv
source/portalTop.sv
dv/portalTb.sv

//--- dv/portalTb.sv
`timescale 1ns/1ns

module portalTb;

  localparam int Limit = 300; // Cycles allowed per wait

  logic CLK, RST_N;
  logic arValid, arReady, rValid, rReady, rLast;
  logic awValid, awReady, wValid, wReady, bValid, bReady;
  logic reqValid, reqReady, indValid, indReady, interrupt;
  logic [12:0] arAddr, awAddr;
  logic [3:0] arLen, awLen;
  logic [5:0] arId, awId, rId, bId;
  logic [31:0] rData, wData;
  logic [127:0] reqData, indData;

  int seed = 46095;
  int readySeed = 46095;
  int errors, checks, tests, testErrors;
  logic [31:0] wrWords [16];
  logic [31:0] indModel [$];   // Indication words still to be popped
  logic [38:0] expRead [$];    // {data, id, last}
  logic [5:0] expB [$];
  logic [127:0] expMsg [$];
  logic [38:0] readExp;

  portalTop #(.MsgWords(4), .AddrFifoDepth(2), .RespFifoDepth(2)) dut (.*);

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  function automatic logic [31:0] expectedRead(input logic [12:0] addr, input logic pending,
                                               input logic [31:0] head);
    logic reqSide;
    logic [4:0] off;
    reqSide = addr[12];
    off = addr[4:0];
    if (addr[11:5] == 7'd0) begin
      case (off)
        5'h00, 5'h0C: return {31'd0, pending && !reqSide};
        5'h08: return 32'd1;
        5'h10: return reqSide ? 32'd6 : 32'd5;
        5'h14: return 32'd2;
        default: return 32'h005A05A0;
      endcase
    end
    if (off == 5'h04)
      return 32'd1; // Request queue has room
    if (off == 5'h00 && !reqSide && pending)
      return head;
    return 32'd0;
  endfunction

  task automatic checkValue(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic timeoutFail(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic busRead(input logic [12:0] addr, input logic [3:0] len, input logic [5:0] id);
    int t, i;
    logic [12:0] beatAddr;
    logic pending;
    @(posedge CLK);
    #1;
    arValid = 1'b1;
    arAddr = addr;
    arLen = len;
    arId = id;
    t = 0;
    @(negedge CLK);
    while (!arReady) begin
      t++;
      if (t > Limit)
        timeoutFail("arReady");
      @(negedge CLK);
    end
    @(posedge CLK);
    #1 arValid = 1'b0;
    for (i = 0; i <= int'(len); i++) begin
      beatAddr = {addr[12:5], 5'(addr[4:0] + 4 * i)}; // Offset wraps in the page
      pending = indModel.size() > 0;
      expRead.push_back({expectedRead(beatAddr, pending, pending ? indModel[0] : 32'd0),
                         id, i == int'(len)});
      if (pending && !beatAddr[12] && beatAddr[11:5] != 7'd0 && beatAddr[4:0] == 5'd0)
        void'(indModel.pop_front());
    end
  endtask

  task automatic busWrite(input logic [12:0] addr, input logic [3:0] len, input logic [5:0] id);
    int t, i;
    @(posedge CLK);
    #1;
    awValid = 1'b1;
    awAddr = addr;
    awLen = len;
    awId = id;
    t = 0;
    @(negedge CLK);
    while (!awReady) begin
      t++;
      if (t > Limit)
        timeoutFail("awReady");
      @(negedge CLK);
    end
    @(posedge CLK);
    #1 awValid = 1'b0;
    expB.push_back(id);
    for (i = 0; i <= int'(len); i++) begin
      wValid = 1'b1;
      wData = wrWords[i];
      t = 0;
      @(negedge CLK);
      while (!wReady) begin
        t++;
        if (t > Limit)
          timeoutFail("wReady");
        @(negedge CLK);
      end
      @(posedge CLK);
      #1 wValid = 1'b0;
    end
  endtask

  // Random message body with its length in the header
  task automatic randomWords(input int n);
    int i;
    for (i = 0; i < n; i++)
      wrWords[i] = $random(seed);
    wrWords[0][15:0] = 16'(n);
  endtask

  task automatic sendIndication(input int n);
    int t, i;
    @(posedge CLK);
    #1;
    indData = '0;
    for (i = 0; i < n; i++) begin
      indData[i*32 +: 32] = wrWords[i];
      indModel.push_back(wrWords[i]);
    end
    indValid = 1'b1;
    t = 0;
    @(negedge CLK);
    while (!indReady) begin
      t++;
      if (t > Limit)
        timeoutFail("indReady");
      @(negedge CLK);
    end
    @(posedge CLK);
    #1 indValid = 1'b0;
  endtask

  task automatic drainAll();
    int t;
    t = 0;
    while (expRead.size() > 0 || expB.size() > 0 || expMsg.size() > 0) begin
      @(negedge CLK);
      t++;
      if (t > Limit)
        timeoutFail("outstanding responses");
    end
  endtask

  task automatic checkInterrupt(input logic exp);
    @(negedge CLK);
    checkValue("interrupt", 128'(interrupt), 128'(exp));
  endtask

  task automatic endTest(input string name);
    tests++;
    $display("Test %0s: %0d errors", name, errors - testErrors);
    testErrors = errors;
  endtask

  // Ready drops on the response channels
  initial begin
    rReady = 1'b0;
    bReady = 1'b0;
    forever begin
      @(posedge CLK);
      #1;
      rReady = ($random(readySeed) & 3) != 0;
      bReady = ($random(readySeed) & 1) != 0;
    end
  end

  // Response compare, transfers complete at the next rising edge
  always @(negedge CLK) begin
    if (RST_N && rValid && rReady) begin
      if (expRead.size() == 0) begin
        errors++;
        $display("Read response with id %0d arrived unexpectedly at %0t", rId, $time);
      end else begin
        readExp = expRead.pop_front();
        checkValue("rData", 128'(rData), 128'(readExp[38:7]));
        checkValue("rId", 128'(rId), 128'(readExp[6:1]));
        checkValue("rLast", 128'(rLast), 128'(readExp[0]));
      end
    end
    if (RST_N && bValid && bReady) begin
      if (expB.size() == 0) begin
        errors++;
        $display("Write response with id %0d arrived unexpectedly at %0t", bId, $time);
      end else
        checkValue("bId", 128'(bId), 128'(expB.pop_front()));
    end
    if (RST_N && reqValid && reqReady) begin
      if (expMsg.size() == 0) begin
        errors++;
        $display("Request message arrived unexpectedly at %0t", $time);
      end else
        checkValue("reqData", reqData, expMsg.pop_front());
    end
  end

  initial begin
    int port, off, n, i, k;
    logic [127:0] msg;
    RST_N = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    awValid = 1'b0;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    wValid = 1'b0;
    wData = '0;
    reqReady = 1'b1;
    indValid = 1'b0;
    indData = '0;
    repeat (8) @(posedge CLK);
    #1 RST_N = 1'b1;

    @(negedge CLK);
    checkValue("rValid", 128'(rValid), 128'd0);
    checkValue("bValid", 128'(bValid), 128'd0);
    checkValue("reqValid", 128'(reqValid), 128'd0);
    checkValue("interrupt", 128'(interrupt), 128'd0);
    for (port = 0; port < 2; port++)
      for (off = 0; off < 32; off += 4)
        busRead({port[0], 7'd0, 5'(off)}, 4'd0, 6'($random(seed)));
    drainAll();
    endTest("control registers");

    busRead(13'h0008, 4'd3, 6'd17);
    busRead(13'h1020, 4'd3, 6'd42);
    busRead(13'h1014, 4'd3, 6'($random(seed))); // Wraps to offset 0
    drainAll();
    endTest("read bursts");

    for (k = 0; k < 6; k++) begin
      n = 1 + ($random(seed) & 3);
      randomWords(n);
      msg = '0;
      for (i = 0; i < n; i++)
        msg[i*32 +: 32] = wrWords[i];
      expMsg.push_back(msg);
      busWrite({1'b1, 7'd1, 5'(0 - 4 * (n - 1))}, 4'(n - 1), 6'($random(seed)));
    end
    drainAll();
    endTest("request messages");

    randomWords(3);
    sendIndication(3);
    busRead(13'h0000, 4'd3, 6'd9);
    busRead(13'h1000, 4'd0, 6'd10);
    for (i = 0; i < 4; i++)
      busRead(13'h0020, 4'd1, 6'(20 + i)); // Pop at 0, room flag at 4
    drainAll();
    endTest("indication messages");

    randomWords(2);
    sendIndication(2);
    checkInterrupt(1'b0);
    wrWords[0] = 32'd1;
    busWrite(13'h0004, 4'd0, 6'd33);
    drainAll();
    checkInterrupt(1'b1);
    busRead(13'h0020, 4'd0, 6'd34);
    drainAll();
    checkInterrupt(1'b1);
    busRead(13'h0020, 4'd0, 6'd35);
    drainAll();
    checkInterrupt(1'b0);
    endTest("interrupt");

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module portalTb \
  -Mdir obj_dir -o portalSim

out=$(./obj_dir/portalSim)
echo "$out"

if grep -q "Simulation PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- source/burstSplitter.sv
`timescale 1ns/1ns

module burstSplitter import portalPkg::*; #(
  parameter int AddrFifoDepth = 2
) (
  input  logic CLK,
  input  logic RST_N,
  input  logic addrValid,
  output logic addrReady,
  input  logic [AddrWidth-1:0] addr,
  input  logic [LenWidth-1:0] len,
  input  logic [IdWidth-1:0] id,
  portalBeatIf.source beats
);

  // Queued request: offset, length, id, control page, request portal
  localparam int ReqWidth = OffsetWidth + LenWidth + IdWidth + 2;

  logic [ReqWidth-1:0] reqIn, reqOut;
  logic fifoFull, fifoEmpty, take, fire, burstDone;
  logic [OffsetWidth-1:0] headOffset, stepOffset;
  logic [LenWidth-1:0] headLen, beatCount;
  logic [IdWidth-1:0] headId;
  logic headCtrl, headReq, isCtrl;

  assign isCtrl = addr[PageMsb:PageLsb] == '0;
  assign reqIn = {addr[OffsetWidth-1:0], len, id, isCtrl, addr[PortalSelBit]};
  assign {headOffset, headLen, headId, headCtrl, headReq} = reqOut;

  assign addrReady = !fifoFull;
  assign take = addrValid && !fifoFull;

  // Head stays queued until its final beat leaves
  syncFifo #(.Width(ReqWidth), .Depth(AddrFifoDepth)) addrFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .enq(take),
    .dataIn(reqIn),
    .deq(burstDone),
    .dataOut(reqOut),
    .full(fifoFull),
    .empty(fifoEmpty)
  );

  assign beats.valid = !fifoEmpty;
  assign beats.beat = '{
    offset: headOffset + stepOffset,
    id: headId,
    ctrlPage: headCtrl,
    reqPortal: headReq,
    last: beatCount == headLen
  };

  assign fire = beats.valid && beats.ready;
  assign burstDone = fire && beats.beat.last;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      beatCount <= '0;
      stepOffset <= '0;
    end else if (burstDone) begin
      beatCount <= '0;
      stepOffset <= '0;
    end else if (fire) begin
      beatCount <= beatCount + 1'b1;
      stepOffset <= stepOffset + OffsetWidth'(4); // One word per beat
    end
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    beats.valid && !beats.ready |=> beats.valid && $stable(beats.beat))
    else $error("burstSplitter: beat changed while stalled");

endmodule

//--- source/indicationBuffer.sv
`timescale 1ns/1ns

module indicationBuffer import portalPkg::*; #(
  parameter int MsgWords = 4
) (
  input  logic CLK,
  input  logic RST_N,
  input  logic indValid,
  output logic indReady,
  input  logic [MsgWords*DataWidth-1:0] indData,
  input  logic pop,
  output logic pending,
  output logic [DataWidth-1:0] word,
  input  logic intEnable,
  output logic interrupt
);

  logic [MsgWords*DataWidth-1:0] msgBuf;
  logic [MsgLenWidth-1:0] remaining; // Words left, header included

  assign pending = remaining != '0;
  assign indReady = !pending;
  assign word = msgBuf[DataWidth-1:0];
  assign interrupt = pending && intEnable;

  always_ff @(posedge CLK) begin
    if (indValid && indReady)
      msgBuf <= indData;
    else if (pop && pending)
      msgBuf <= msgBuf >> DataWidth;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N)
      remaining <= '0;
    else if (indValid && indReady)
      remaining <= indData[MsgLenWidth-1:0];
    else if (pop && pending)
      remaining <= remaining - 1'b1;
  end

  // Reader only pops what the buffer reports
  assert property (@(posedge CLK) disable iff (!RST_N) pop |-> pending)
    else $error("indicationBuffer: pop with nothing pending");

endmodule

//--- source/messageAssembler.sv
`timescale 1ns/1ns

module messageAssembler import portalPkg::*; #(
  parameter int MsgWords = 4
) (
  input  logic CLK,
  input  logic RST_N,
  input  logic wordValid,
  input  logic [DataWidth-1:0] word,
  input  logic wordLast,
  output logic wordReady,
  output logic reqValid,
  input  logic reqReady,
  output logic [MsgWords*DataWidth-1:0] reqData
);

  localparam int PosWidth = $clog2(MsgWords + 1);

  logic [MsgWords*DataWidth-1:0] msgBuf;
  logic [PosWidth-1:0] pos;
  logic take;

  assign wordReady = !reqValid; // Hold off while a message waits
  assign take = wordValid && wordReady;
  assign reqData = msgBuf;

  always_ff @(posedge CLK) begin
    if (take) begin
      if (pos == '0)
        msgBuf <= {{((MsgWords - 1) * DataWidth){1'b0}}, word}; // Clears the rest
      else if (pos < PosWidth'(MsgWords))
        msgBuf[pos*DataWidth +: DataWidth] <= word;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      pos <= '0;
      reqValid <= 1'b0;
    end else if (reqValid && reqReady) begin
      pos <= '0;
      reqValid <= 1'b0;
    end else if (take) begin
      if (pos < PosWidth'(MsgWords))
        pos <= pos + 1'b1;   // Saturates, extra words dropped
      reqValid <= wordLast;
    end
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    reqValid && !reqReady |=> reqValid && $stable(reqData))
    else $error("messageAssembler: message changed while waiting");

endmodule

//--- source/portalBeatIf.sv
`timescale 1ns/1ns

// One burst beat from a splitter to a read or write engine
interface portalBeatIf import portalPkg::*; ();

  logic valid;
  logic ready;
  beatT beat;

  modport source (
    output valid,
    output beat,
    input  ready
  );

  modport sink (
    input  valid,
    input  beat,
    output ready
  );

endinterface

//--- source/portalPkg.sv
package portalPkg;

  localparam int DataWidth = 32;
  localparam int IdWidth = 6;
  localparam int LenWidth = 4;    // Burst has len + 1 beats
  localparam int OffsetWidth = 5;
  localparam int AddrWidth = 13;

  // Address map
  localparam int PortalSelBit = 12;
  localparam int PageLsb = 5;
  localparam int PageMsb = 11;

  localparam int MsgLenWidth = 16; // Header length field, words incl. header

  localparam logic [DataWidth-1:0] NumTiles = 32'd1;
  localparam logic [DataWidth-1:0] NumPortals = 32'd2;
  localparam logic [DataWidth-1:0] IndPortalId = 32'd5;
  localparam logic [DataWidth-1:0] ReqPortalId = 32'd6;
  localparam logic [DataWidth-1:0] UnusedRegValue = 32'h005A05A0;

  typedef enum logic [OffsetWidth-1:0] {
    CtrlIntStatus   = 5'h00,
    CtrlIntEnable   = 5'h04,
    CtrlNumTiles    = 5'h08,
    CtrlQueueStatus = 5'h0C,
    CtrlPortalId    = 5'h10,
    CtrlNumPortals  = 5'h14
  } ctrlRegE;

  typedef struct packed {
    logic [OffsetWidth-1:0] offset;
    logic [IdWidth-1:0] id;
    logic ctrlPage;
    logic reqPortal;
    logic last;
  } beatT;

endpackage

//--- source/portalRead.sv
`timescale 1ns/1ns

module portalRead import portalPkg::*; #(
  parameter int RespFifoDepth = 2
) (
  input  logic CLK,
  input  logic RST_N,
  portalBeatIf.sink beats,
  output logic rValid,
  input  logic rReady,
  output logic [DataWidth-1:0] rData,
  output logic [IdWidth-1:0] rId,
  output logic rLast,
  input  logic indPending,
  input  logic [DataWidth-1:0] indWord,
  output logic indPop,
  input  logic reqNotFull
);

  localparam int RespWidth = DataWidth + IdWidth + 1;

  beatT beat;
  logic respFull, respEmpty, consume;
  logic [DataWidth-1:0] ctrlValue, dataValue, statusValue;
  logic [RespWidth-1:0] respIn, respOut;

  assign beat = beats.beat;
  assign beats.ready = !respFull;
  assign consume = beats.valid && !respFull;

  // Only the indication portal ever has something pending
  assign statusValue = {{(DataWidth - 1){1'b0}}, indPending && !beat.reqPortal};

  always_comb begin
    case (ctrlRegE'(beat.offset))
      CtrlIntStatus:   ctrlValue = statusValue;
      CtrlIntEnable:   ctrlValue = UnusedRegValue; // Write only
      CtrlNumTiles:    ctrlValue = NumTiles;
      CtrlQueueStatus: ctrlValue = statusValue;
      CtrlPortalId:    ctrlValue = beat.reqPortal ? ReqPortalId : IndPortalId;
      CtrlNumPortals:  ctrlValue = NumPortals;
      default:         ctrlValue = UnusedRegValue;
    endcase
  end

  always_comb begin
    dataValue = '0;
    if (beat.offset == OffsetWidth'(4)) // Request space flag on both portals
      dataValue = {{(DataWidth - 1){1'b0}}, reqNotFull};
    else if (beat.offset == '0 && !beat.reqPortal && indPending)
      dataValue = indWord;
  end

  // Empty indication reads return zero and pop nothing
  assign indPop = consume && !beat.ctrlPage && !beat.reqPortal &&
                  beat.offset == '0 && indPending;

  assign respIn = {beat.ctrlPage ? ctrlValue : dataValue, beat.id, beat.last};

  syncFifo #(.Width(RespWidth), .Depth(RespFifoDepth)) respFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .enq(consume),
    .dataIn(respIn),
    .deq(rValid && rReady),
    .dataOut(respOut),
    .full(respFull),
    .empty(respEmpty)
  );

  assign rValid = !respEmpty;
  assign {rData, rId, rLast} = respOut;

endmodule

//--- source/portalTop.sv
`timescale 1ns/1ns

module portalTop import portalPkg::*; #(
  parameter int MsgWords = 4,
  parameter int AddrFifoDepth = 2,
  parameter int RespFifoDepth = 2
) (
  input  logic CLK,
  input  logic RST_N,
  input  logic arValid,
  output logic arReady,
  input  logic [AddrWidth-1:0] arAddr,
  input  logic [LenWidth-1:0] arLen,
  input  logic [IdWidth-1:0] arId,
  output logic rValid,
  input  logic rReady,
  output logic [DataWidth-1:0] rData,
  output logic [IdWidth-1:0] rId,
  output logic rLast,
  input  logic awValid,
  output logic awReady,
  input  logic [AddrWidth-1:0] awAddr,
  input  logic [LenWidth-1:0] awLen,
  input  logic [IdWidth-1:0] awId,
  input  logic wValid,
  output logic wReady,
  input  logic [DataWidth-1:0] wData,
  output logic bValid,
  input  logic bReady,
  output logic [IdWidth-1:0] bId,
  output logic reqValid,
  input  logic reqReady,
  output logic [MsgWords*DataWidth-1:0] reqData,
  input  logic indValid,
  output logic indReady,
  input  logic [MsgWords*DataWidth-1:0] indData,
  output logic interrupt
);

  logic indPending, indPop, intEnable;
  logic [DataWidth-1:0] indWord, reqWord;
  logic reqWordValid, reqWordLast, reqWordReady;

  portalBeatIf readBeats ();
  portalBeatIf writeBeats ();

  burstSplitter #(.AddrFifoDepth(AddrFifoDepth)) readSplit (
    .CLK(CLK), .RST_N(RST_N), .addrValid(arValid), .addrReady(arReady),
    .addr(arAddr), .len(arLen), .id(arId), .beats(readBeats)
  );

  burstSplitter #(.AddrFifoDepth(AddrFifoDepth)) writeSplit (
    .CLK(CLK), .RST_N(RST_N), .addrValid(awValid), .addrReady(awReady),
    .addr(awAddr), .len(awLen), .id(awId), .beats(writeBeats)
  );

  // Assembler ready doubles as the request queue status
  portalRead #(.RespFifoDepth(RespFifoDepth)) readEngine (
    .CLK(CLK), .RST_N(RST_N), .beats(readBeats),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .indPending(indPending), .indWord(indWord), .indPop(indPop),
    .reqNotFull(reqWordReady)
  );

  portalWrite #(.RespFifoDepth(RespFifoDepth)) writeEngine (
    .CLK(CLK), .RST_N(RST_N), .beats(writeBeats),
    .wValid(wValid), .wReady(wReady), .wData(wData),
    .bValid(bValid), .bReady(bReady), .bId(bId), .intEnable(intEnable),
    .reqWordValid(reqWordValid), .reqWord(reqWord), .reqWordLast(reqWordLast),
    .reqWordReady(reqWordReady)
  );

  messageAssembler #(.MsgWords(MsgWords)) assembler (
    .CLK(CLK), .RST_N(RST_N), .wordValid(reqWordValid), .word(reqWord),
    .wordLast(reqWordLast), .wordReady(reqWordReady),
    .reqValid(reqValid), .reqReady(reqReady), .reqData(reqData)
  );

  indicationBuffer #(.MsgWords(MsgWords)) indBuffer (
    .CLK(CLK), .RST_N(RST_N), .indValid(indValid), .indReady(indReady),
    .indData(indData), .pop(indPop), .pending(indPending), .word(indWord),
    .intEnable(intEnable), .interrupt(interrupt)
  );

endmodule

//--- source/portalWrite.sv
`timescale 1ns/1ns

module portalWrite import portalPkg::*; #(
  parameter int RespFifoDepth = 2
) (
  input  logic CLK,
  input  logic RST_N,
  portalBeatIf.sink beats,
  input  logic wValid,
  output logic wReady,
  input  logic [DataWidth-1:0] wData,
  output logic bValid,
  input  logic bReady,
  output logic [IdWidth-1:0] bId,
  output logic intEnable,
  output logic reqWordValid,
  output logic [DataWidth-1:0] reqWord,
  output logic reqWordLast,
  input  logic reqWordReady
);

  beatT beat;
  logic dataFull, dataEmpty, respFull, respEmpty;
  logic isReqData, respRoom, consume;
  logic [DataWidth-1:0] dataOut;

  assign beat = beats.beat;
  assign isReqData = !beat.ctrlPage && beat.reqPortal;
  assign respRoom = !beat.last || !respFull;

  syncFifo #(.Width(DataWidth), .Depth(RespFifoDepth)) dataFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .enq(wValid && wReady),
    .dataIn(wData),
    .deq(consume),
    .dataOut(dataOut),
    .full(dataFull),
    .empty(dataEmpty)
  );

  assign wReady = !dataFull;

  // Beat and data word leave together
  assign beats.ready = !dataEmpty && respRoom && (!isReqData || reqWordReady);
  assign consume = beats.valid && beats.ready;

  assign reqWordValid = beats.valid && !dataEmpty && respRoom && isReqData;
  assign reqWord = dataOut;
  assign reqWordLast = beat.offset == '0; // Offset 0 closes the message

  always_ff @(posedge CLK) begin
    if (!RST_N)
      intEnable <= 1'b0;
    else if (consume && beat.ctrlPage && beat.offset == CtrlIntEnable)
      intEnable <= dataOut[0];
  end

  syncFifo #(.Width(IdWidth), .Depth(RespFifoDepth)) respFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .enq(consume && beat.last),
    .dataIn(beat.id),
    .deq(bValid && bReady),
    .dataOut(bId),
    .full(respFull),
    .empty(respEmpty)
  );

  assign bValid = !respEmpty;

  // Word offer to the assembler is never withdrawn
  assert property (@(posedge CLK) disable iff (!RST_N)
    reqWordValid && !reqWordReady |=> reqWordValid && $stable(reqWord))
    else $error("portalWrite: request word dropped while stalled");

endmodule

//--- source/syncFifo.sv
`timescale 1ns/1ns

module syncFifo #(
  parameter int Width = 8,
  parameter int Depth = 2
) (
  input  logic CLK,
  input  logic RST_N,
  input  logic enq,
  input  logic [Width-1:0] dataIn,
  input  logic deq,
  output logic [Width-1:0] dataOut,
  output logic full,
  output logic empty
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0] mem [Depth];
  logic [PtrWidth-1:0] wrPtr, rdPtr;
  logic [PtrWidth:0] count;

  assign dataOut = mem[rdPtr];
  assign full = count == (PtrWidth + 1)'(Depth);
  assign empty = count == '0;

  always_ff @(posedge CLK) begin
    if (enq)
      mem[wrPtr] <= dataIn;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (enq)
        wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (deq)
        rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      if (enq && !deq)
        count <= count + 1'b1;
      else if (deq && !enq)
        count <= count - 1'b1;
    end
  end

  // Callers must respect the flags
  assert property (@(posedge CLK) disable iff (!RST_N) enq |-> !full)
    else $error("syncFifo: enqueue while full");
  assert property (@(posedge CLK) disable iff (!RST_N) deq |-> !empty)
    else $error("syncFifo: dequeue while empty");

endmodule
